/* cpu_core.f */
+incdir+test
source/cpu_pkg.sv
source/reg_file.sv
source/muxs.sv
source/decoder.sv
source/execute_unit.sv
source/data_mem.sv
source/cpu_core.sv
test/tb_cpu_core.sv

/* Makefile */
SOURCES := $(filter-out +incdir+%,$(shell cat cpu_core.f)) test/tb_ref_model.svh

all: run

obj_dir/Vtb_cpu_core: cpu_core.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cpu_core -f cpu_core.f -o Vtb_cpu_core

run: obj_dir/Vtb_cpu_core
	obj_dir/Vtb_cpu_core | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* test/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [data_width-1:0] arch_regs [reg_count]; // Architectural register state
logic [data_width-1:0] arch_mem [mem_depth];

// The immediate view overlaps ra, so ra is written after the immediate
function automatic logic [31:0] encode(input logic [5:0] op, input logic [4:0] fn,
		input logic [4:0] rt, input logic [4:0] ra, input logic [4:0] rb,
		input logic [1:0] sv, input logic [19:0] imm);
	instr_t w;
	w = '0;
	if (op == op_alu_r || op == op_lw || op == op_sw) begin
		w.r.opcode    = op;
		w.r.rt        = rt;
		w.r.ra        = ra;
		w.r.rb        = rb;
		w.r.sub_op_sv = sv;
		w.r.funct     = fn;
	end else begin
		w.i.opcode    = op;
		w.i.rt        = rt;
		w.i.imm_20bit = (op == op_movi) ? imm : {5'd0, imm[14:0]};
		if (op != op_movi) begin
			w.r.ra = ra;
		end
	end
	return w;
endfunction

// Runs one instruction in program order and returns its write-back
function automatic void predict(input logic [5:0] op, input logic [4:0] fn,
		input logic [4:0] rt, input logic [4:0] ra, input logic [4:0] rb,
		input logic [1:0] sv, input logic [19:0] imm,
		output logic wr, output logic [31:0] val);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] se15;
	logic [31:0] addr;
	a    = arch_regs[ra];
	b    = arch_regs[rb];
	se15 = {{17{imm[14]}}, imm[14:0]};
	if (op == op_lw) begin
		addr = a + (b << sv);
	end else if (op == op_sw) begin
		addr = a + (arch_regs[rt] << sv); // The stored register is also the index
	end else begin
		addr = a + (se15 << 2);
	end
	wr  = (rt != '0);
	val = '0;
	case (op)
		op_alu_r: begin
			case (fn)
				fn_add: val = a + b;
				fn_sub: val = a - b;
				fn_and: val = a & b;
				fn_or: val = a | b;
				fn_xor: val = a ^ b;
				fn_sll: val = a << b[4:0];
				default: wr = 1'b0;
			endcase
		end
		op_addi: val = a + se15;
		op_ori: val = a | {17'd0, imm[14:0]};
		op_slli: val = a << imm[4:0];
		op_movi: val = {{12{imm[19]}}, imm};
		op_lwi, op_lw: val = arch_mem[addr[9:2]];
		op_swi, op_sw: begin
			arch_mem[addr[9:2]] = arch_regs[rt];
			wr = 1'b0;
		end
		default: wr = 1'b0;
	endcase
	if (wr) begin
		arch_regs[rt] = val;
	end
endfunction

`endif

/* test/tb_cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core
	import cpu_pkg::*;
();

	localparam int unsigned seed = 62551;
	localparam int clk_period = 8;
	localparam int n_alu = 400;
	localparam int n_imm = 300;
	localparam int n_mem = 400;
	localparam int n_chain = 400;
	localparam int max_gap = 2;
	localparam int n_slots = 3 + (reg_count - 1) + 2 * mem_depth + 9 + n_alu + n_imm + n_mem
		+ n_chain * (max_gap + 1) + 4;

	localparam logic [4:0] alu_fns [6] = '{fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_sll};
	localparam logic [5:0] imm_ops [4] = '{op_addi, op_ori, op_slli, op_movi};
	localparam logic [5:0] mem_ops [4] = '{op_lwi, op_swi, op_lw, op_sw};
	localparam logic [5:0] all_ops [9] = '{op_alu_r, op_addi, op_ori, op_slli, op_movi,
		op_lwi, op_swi, op_lw, op_sw};

	typedef struct packed {
		int unsigned cyc;
		logic [4:0]  rd;
		logic [31:0] val;
	} wb_exp_t;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] instr;
	logic        instr_valid;
	logic        wb_we;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;

	wb_exp_t     expected [$];
	wb_exp_t     head;
	int unsigned cycle = 0;
	int          checked = 0;
	int          mismatches = 0;
	int          other_errors = 0;

	`include "tb_ref_model.svh"

	cpu_core u_cpu_core (
		.clk, .rst, .instr, .instr_valid, .wb_we, .wb_reg, .wb_data
	);

	initial begin
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// ##########################################################
	// Stimulus helpers
	// ##########################################################
	function automatic logic [4:0] pick_reg(input int unsigned pool);
		int unsigned r;
		r = $urandom_range(pool - 1, 0);
		return r[4:0];
	endfunction

	task automatic bubble();
		instr       = $urandom; // Garbage word without the strobe
		instr_valid = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic run_op(input logic [5:0] op, input logic [4:0] fn, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv,
			input logic [19:0] imm);
		wb_exp_t     e;
		logic        wr;
		logic [31:0] val;
		instr       = encode(op, fn, rt, ra, rb, sv, imm);
		instr_valid = 1'b1;
		predict(op, fn, rt, ra, rb, sv, imm, wr, val);
		if (wr) begin
			e.cyc = cycle + 2; // Sampled on the next edge, retires one edge later
			e.rd  = rt;
			e.val = val;
			expected.push_back(e);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic random_op(input logic [5:0] op, input int unsigned pool);
		logic [31:0] rnd;
		rnd = $urandom;
		run_op(op, alu_fns[$urandom_range(5, 0)], pick_reg(pool), pick_reg(pool),
			pick_reg(pool), rnd[9:8], rnd[19:0]);
	endtask

	// ##########################################################
	// Write-back checks
	// ##########################################################
	always @(negedge clk) begin
		if (expected.size() != 0 && expected[0].cyc == cycle) begin
			head = expected.pop_front();
			checked++;
			assert (wb_we === 1'b1) else begin
				mismatches++;
				$display("mismatch at %0d ns: wb_we expected 1 got %b", $time, wb_we);
			end
			assert (wb_reg === head.rd) else begin
				mismatches++;
				$display("mismatch at %0d ns: wb_reg expected %0d got %0d",
					$time, head.rd, wb_reg);
			end
			assert (wb_data === head.val) else begin
				mismatches++;
				$display("mismatch at %0d ns: wb_data expected %h got %h",
					$time, head.val, wb_data);
			end
		end else begin
			assert (wb_we === 1'b0) else begin
				mismatches++;
				$display("mismatch at %0d ns: wb_we expected 0 got %b", $time, wb_we);
			end
		end
	end

	initial begin
		#(clk_period * (n_slots + 20));
		$display("error: watchdog timeout, the instruction stream did not finish in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ##########################################################
	// Test sequence
	// ##########################################################
	initial begin
		logic [31:0] rnd;
		void'($urandom(seed));
		rst         = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		for (int i = 0; i < reg_count; i++) begin
			arch_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) bubble();

		for (int i = 1; i < reg_count; i++) begin
			rnd = $urandom;
			run_op(op_movi, fn_add, i[4:0], 5'd0, 5'd0, 2'd0, rnd[19:0]);
		end
		// Every word gets a value built from its own index
		for (int w = 0; w < mem_depth; w++) begin
			run_op(op_movi, fn_add, 5'd1, 5'd0, 5'd0, 2'd0, {4'h9, w[7:0], ~w[7:0]});
			run_op(op_swi, fn_add, 5'd1, 5'd0, 5'd0, 2'd0, {12'd0, w[7:0]});
		end

		repeat (n_alu) random_op(op_alu_r, 32);
		run_op(op_movi, fn_add, 5'd4, 5'd0, 5'd0, 2'd0, 20'hA5A5A); // Negative
		run_op(op_movi, fn_add, 5'd5, 5'd0, 5'd0, 2'd0, 20'h5A5A5);
		repeat (n_imm) random_op(imm_ops[$urandom_range(3, 0)], 32);
		repeat (n_mem) random_op(mem_ops[$urandom_range(3, 0)], 32);

		// Load then use at distance 1 and 2, then r0 as a target and a source
		run_op(op_lwi, fn_add, 5'd1, 5'd0, 5'd0, 2'd0, 20'd5);
		run_op(op_alu_r, fn_add, 5'd2, 5'd1, 5'd1, 2'd0, 20'd0);
		run_op(op_alu_r, fn_sub, 5'd3, 5'd1, 5'd2, 2'd0, 20'd0);
		run_op(op_addi, fn_add, 5'd0, 5'd1, 5'd0, 2'd0, 20'd77);
		run_op(op_alu_r, fn_or, 5'd6, 5'd0, 5'd1, 2'd0, 20'd0);
		run_op(op_lw, fn_add, 5'd7, 5'd6, 5'd3, 2'd1, 20'd0);
		run_op(op_sw, fn_add, 5'd7, 5'd2, 5'd0, 2'd2, 20'd0);

		for (int i = 0; i < n_chain; i++) begin
			random_op(all_ops[$urandom_range(8, 0)], 4); // Small pool forces hazards
			repeat ($urandom_range(max_gap, 0)) bubble();
		end
		repeat (4) bubble();

		if (expected.size() != 0) begin
			other_errors++;
			$display("error: %0d expected write-backs never appeared", expected.size());
		end
		$display("summary: %0d write-backs checked, %0d mismatches, %0d other errors",
			checked, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core
	import cpu_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic [data_width-1:0]     instr,
	input  logic                      instr_valid,
	output logic                      wb_we,
	output logic [reg_addr_width-1:0] wb_reg,
	output logic [data_width-1:0]     wb_data
);

	logic [reg_addr_width-1:0] rd_a_addr;
	logic [reg_addr_width-1:0] rd_b_addr;
	logic [data_width-1:0]     rd_a_data;
	logic [data_width-1:0]     rd_b_data;

	logic                      ex_valid;
	alu_op_t                   ex_alu_op;
	logic [2:0]                ex_sel_alu_src2;
	logic [1:0]                ex_sel_imm_extend;
	logic [1:0]                ex_sel_write_reg;
	logic [1:0]                ex_sub_op_sv;
	logic [19:0]               ex_imm_20bit;
	logic [reg_addr_width-1:0] ex_rt;
	logic                      ex_mem_we;
	logic [reg_addr_width-1:0] ex_ra;
	logic [reg_addr_width-1:0] ex_rb;
	logic [data_width-1:0]     ex_a_data;
	logic [data_width-1:0]     ex_b_data;

	logic [data_width-1:0]     fwd_rb_data;
	logic [4:0]                imm_5bit;
	logic [14:0]               imm_15bit;
	logic [data_width-1:0]     alu_src2;
	logic [data_width-1:0]     imm_extend;
	logic [mem_addr_width-1:0] mem_addr;
	logic [data_width-1:0]     mem_wdata;
	logic                      mem_we;
	logic [data_width-1:0]     mem_read_data;
	logic [1:0]                wb_sel;
	logic [data_width-1:0]     alu_result;
	logic [data_width-1:0]     xreg3_imm_extend;

	decoder u_decoder (
		.clk, .rst, .instr, .instr_valid, .rd_a_data, .rd_b_data,
		.rd_a_addr, .rd_b_addr, .ex_valid, .ex_alu_op, .ex_sel_alu_src2,
		.ex_sel_imm_extend, .ex_sel_write_reg, .ex_sub_op_sv, .ex_imm_20bit,
		.ex_rt, .ex_mem_we, .ex_ra, .ex_rb, .ex_a_data, .ex_b_data
	);

	reg_file u_reg_file (
		.clk, .rst, .rd_a_addr, .rd_b_addr,
		.we(wb_we), .wr_addr(wb_reg), .wr_data(wb_data),
		.rd_a_data, .rd_b_data
	);

	execute_unit u_execute_unit (
		.clk, .rst, .ex_valid, .ex_alu_op, .ex_sel_write_reg, .ex_imm_20bit,
		.ex_rt, .ex_mem_we, .ex_ra, .ex_rb, .ex_a_data, .ex_b_data,
		.alu_src2, .imm_extend, .write_reg_data(wb_data),
		.fwd_rb_data, .imm_5bit, .imm_15bit, .mem_addr, .mem_wdata, .mem_we,
		.wb_we, .wb_reg, .wb_sel, .alu_result, .xreg3_imm_extend
	);

	data_mem u_data_mem (
		.clk, .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(mem_read_data)
	);

	// Operand selection for execute and the write-back selector in one block
	muxs u_muxs (
		.sub_op_sv(ex_sub_op_sv), .reg_rb_data(fwd_rb_data), .alu_result,
		.xreg3_imm_extend, .mem_read_data, .imm_5bit, .imm_15bit,
		.imm_20bit(ex_imm_20bit), .select_alu_src2(ex_sel_alu_src2),
		.select_imm_extend(ex_sel_imm_extend), .select_write_reg(wb_sel),
		.imm_extend, .alu_src2, .write_reg_data(wb_data)
	);

endmodule

`default_nettype wire

/* source/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem
	import cpu_pkg::*;
(
	input  logic                      clk,
	input  logic [mem_addr_width-1:0] addr,
	input  logic [data_width-1:0]     wdata,
	input  logic                      we,
	output logic [data_width-1:0]     rdata
);

	logic [data_width-1:0] mem [mem_depth];

	// Read data lands in the write-back stage together with the other results
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit
	import cpu_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      ex_valid,
	input  alu_op_t                   ex_alu_op,
	input  logic [1:0]                ex_sel_write_reg,
	input  logic [19:0]               ex_imm_20bit,
	input  logic [reg_addr_width-1:0] ex_rt,
	input  logic                      ex_mem_we,
	input  logic [reg_addr_width-1:0] ex_ra,
	input  logic [reg_addr_width-1:0] ex_rb,
	input  logic [data_width-1:0]     ex_a_data,
	input  logic [data_width-1:0]     ex_b_data,
	input  logic [data_width-1:0]     alu_src2,
	input  logic [data_width-1:0]     imm_extend,
	input  logic [data_width-1:0]     write_reg_data,
	output logic [data_width-1:0]     fwd_rb_data,
	output logic [4:0]                imm_5bit,
	output logic [14:0]               imm_15bit,
	output logic [mem_addr_width-1:0] mem_addr,
	output logic [data_width-1:0]     mem_wdata,
	output logic                      mem_we,
	output logic                      wb_we,
	output logic [reg_addr_width-1:0] wb_reg,
	output logic [1:0]                wb_sel,
	output logic [data_width-1:0]     alu_result,
	output logic [data_width-1:0]     xreg3_imm_extend
);

	logic [data_width-1:0] fwd_a_data;
	logic [data_width-1:0] alu_out;

	// wb_we is only ever set for a nonzero wb_reg, so a match never hits r0
	assign fwd_a_data  = (wb_we && wb_reg == ex_ra) ? write_reg_data : ex_a_data;
	assign fwd_rb_data = (wb_we && wb_reg == ex_rb) ? write_reg_data : ex_b_data;

	assign imm_5bit  = ex_imm_20bit[4:0];
	assign imm_15bit = ex_imm_20bit[14:0];

	always_comb begin
		case (ex_alu_op)
			alu_add: alu_out = fwd_a_data + alu_src2;
			alu_sub: alu_out = fwd_a_data - alu_src2;
			alu_and: alu_out = fwd_a_data & alu_src2;
			alu_or: alu_out = fwd_a_data | alu_src2;
			alu_xor: alu_out = fwd_a_data ^ alu_src2;
			alu_sll: alu_out = fwd_a_data << alu_src2[4:0];
			default: alu_out = '0;
		endcase
	end

	// Loads and stores decode to add, so the sum is the byte address
	assign mem_addr  = alu_out[mem_addr_width+1:2];
	assign mem_wdata = fwd_rb_data;
	assign mem_we    = ex_valid & ex_mem_we;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= ex_valid && (ex_rt != '0);
		end
	end

	always_ff @(posedge clk) begin
		wb_reg           <= ex_rt;
		wb_sel           <= ex_sel_write_reg;
		alu_result       <= alu_out;
		xreg3_imm_extend <= imm_extend;
	end

endmodule

`default_nettype wire

/* source/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder
	import cpu_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic [data_width-1:0]     instr,
	input  logic                      instr_valid,
	input  logic [data_width-1:0]     rd_a_data,
	input  logic [data_width-1:0]     rd_b_data,
	output logic [reg_addr_width-1:0] rd_a_addr,
	output logic [reg_addr_width-1:0] rd_b_addr,
	output logic                      ex_valid,
	output alu_op_t                   ex_alu_op,
	output logic [2:0]                ex_sel_alu_src2,
	output logic [1:0]                ex_sel_imm_extend,
	output logic [1:0]                ex_sel_write_reg,
	output logic [1:0]                ex_sub_op_sv,
	output logic [19:0]               ex_imm_20bit,
	output logic [reg_addr_width-1:0] ex_rt,
	output logic                      ex_mem_we,
	output logic [reg_addr_width-1:0] ex_ra,
	output logic [reg_addr_width-1:0] ex_rb,
	output logic [data_width-1:0]     ex_a_data,
	output logic [data_width-1:0]     ex_b_data
);

	instr_t                    ins;
	alu_op_t                   dec_alu_op;
	logic [2:0]                dec_sel_src2;
	logic [1:0]                dec_sel_imm;
	logic [1:0]                dec_sel_wr;
	logic [reg_addr_width-1:0] dec_rt;
	logic [reg_addr_width-1:0] dec_b_idx;
	logic                      dec_mem_we;

	assign ins = instr;

	always_comb begin
		dec_alu_op   = alu_add;
		dec_sel_src2 = alusrc2_rbdata;
		dec_sel_imm  = imm_15bit_se;
		dec_sel_wr   = wrreg_aluresult;
		dec_rt       = ins.r.rt;
		dec_b_idx    = ins.r.rb;
		dec_mem_we   = 1'b0;
		case (ins.r.opcode)
			op_alu_r: begin
				case (ins.r.funct)
					fn_add: dec_alu_op = alu_add;
					fn_sub: dec_alu_op = alu_sub;
					fn_and: dec_alu_op = alu_and;
					fn_or: dec_alu_op = alu_or;
					fn_xor: dec_alu_op = alu_xor;
					fn_sll: dec_alu_op = alu_sll;
					default: dec_rt = '0; // Unknown funct retires without a write
				endcase
			end
			op_addi: dec_sel_src2 = alusrc2_imm;
			op_ori: begin
				dec_sel_src2 = alusrc2_imm;
				dec_sel_imm  = imm_15bit_ze;
				dec_alu_op   = alu_or;
			end
			op_slli: begin
				dec_sel_src2 = alusrc2_imm;
				dec_sel_imm  = imm_5bit_ze;
				dec_alu_op   = alu_sll;
			end
			op_movi: begin
				dec_sel_imm = imm_20bit_se;
				dec_sel_wr  = wrreg_immdata;
			end
			op_lwi: begin
				dec_sel_src2 = alusrc2_lswi;
				dec_sel_wr   = wrreg_mem;
			end
			op_lw: begin
				dec_sel_src2 = alusrc2_lsw;
				dec_sel_wr   = wrreg_mem;
			end
			op_swi, op_sw: begin
				dec_sel_src2 = (ins.r.opcode == op_sw) ? alusrc2_lsw : alusrc2_lswi;
				dec_b_idx    = ins.r.rt; // Port b carries the store data
				dec_rt       = '0;
				dec_mem_we   = 1'b1;
			end
			default: dec_rt = '0;
		endcase
	end

	assign rd_a_addr = ins.r.ra;
	assign rd_b_addr = dec_b_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid  <= 1'b0;
			ex_mem_we <= 1'b0;
			ex_rt     <= '0;
		end else begin
			ex_valid  <= instr_valid;
			ex_mem_we <= instr_valid & dec_mem_we;
			ex_rt     <= instr_valid ? dec_rt : '0;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op         <= dec_alu_op;
		ex_sel_alu_src2   <= dec_sel_src2;
		ex_sel_imm_extend <= dec_sel_imm;
		ex_sel_write_reg  <= dec_sel_wr;
		ex_sub_op_sv      <= ins.r.sub_op_sv;
		ex_imm_20bit      <= ins.i.imm_20bit;
		ex_ra             <= ins.r.ra;
		ex_rb             <= dec_b_idx;
		ex_a_data         <= rd_a_data;
		ex_b_data         <= rd_b_data;
	end

endmodule

`default_nettype wire

/* source/muxs.sv */
`timescale 1ns/1ps
`default_nettype none

module muxs
	import cpu_pkg::*;
(
	input  logic [1:0]            sub_op_sv,
	input  logic [data_width-1:0] reg_rb_data,
	input  logic [data_width-1:0] alu_result,
	input  logic [data_width-1:0] xreg3_imm_extend,
	input  logic [data_width-1:0] mem_read_data,
	input  logic [4:0]            imm_5bit,
	input  logic [14:0]           imm_15bit,
	input  logic [19:0]           imm_20bit,
	input  logic [2:0]            select_alu_src2,
	input  logic [1:0]            select_imm_extend,
	input  logic [1:0]            select_write_reg,
	output logic [data_width-1:0] imm_extend,
	output logic [data_width-1:0] alu_src2,
	output logic [data_width-1:0] write_reg_data
);

	// ##########################################################
	// Immediate extension
	// ##########################################################
	always_comb begin
		case (select_imm_extend)
			imm_5bit_ze: imm_extend = {27'd0, imm_5bit};
			imm_15bit_se: imm_extend = {{17{imm_15bit[14]}}, imm_15bit};
			imm_15bit_ze: imm_extend = {17'd0, imm_15bit};
			imm_20bit_se: imm_extend = {{12{imm_20bit[19]}}, imm_20bit};
			default: imm_extend = '0;
		endcase
	end

	// ##########################################################
	// Second ALU operand
	// ##########################################################
	always_comb begin
		case (select_alu_src2)
			alusrc2_rbdata: alu_src2 = reg_rb_data;
			alusrc2_imm: alu_src2 = imm_extend;
			alusrc2_lswi: alu_src2 = {{15{imm_15bit[14]}}, imm_15bit, 2'b00}; // Word offset
			alusrc2_lsw: alu_src2 = reg_rb_data << sub_op_sv;
			default: alu_src2 = '0;
		endcase
	end

	// ##########################################################
	// Write-back data
	// ##########################################################
	always_comb begin
		case (select_write_reg)
			wrreg_aluresult: write_reg_data = alu_result;
			wrreg_immdata: write_reg_data = xreg3_imm_extend;
			wrreg_mem: write_reg_data = mem_read_data;
			default: write_reg_data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import cpu_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic [reg_addr_width-1:0] rd_a_addr,
	input  logic [reg_addr_width-1:0] rd_b_addr,
	input  logic                      we,
	input  logic [reg_addr_width-1:0] wr_addr,
	input  logic [data_width-1:0]     wr_data,
	output logic [data_width-1:0]     rd_a_data,
	output logic [data_width-1:0]     rd_b_data
);

	logic [data_width-1:0] regs [reg_count];
	logic                  wr_live;

	assign wr_live = we && (wr_addr != '0); // Register zero is hardwired

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-first, so the instruction two behind sees the retiring value
	assign rd_a_data = (rd_a_addr == '0) ? '0 :
		(wr_live && wr_addr == rd_a_addr) ? wr_data : regs[rd_a_addr];
	assign rd_b_data = (rd_b_addr == '0) ? '0 :
		(wr_live && wr_addr == rd_b_addr) ? wr_data : regs[rd_b_addr];

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// ##########################################################
	// Widths
	// ##########################################################
	localparam int data_width     = 32;
	localparam int reg_addr_width = 5;
	localparam int mem_addr_width = 8;
	localparam int reg_count      = 1 << reg_addr_width;
	localparam int mem_depth      = 1 << mem_addr_width;

	// ##########################################################
	// Opcodes and function codes
	// ##########################################################
	localparam logic [5:0] op_alu_r = 6'b100000; // Register ALU group, chosen by funct
	localparam logic [5:0] op_addi  = 6'b101000;
	localparam logic [5:0] op_ori   = 6'b101100;
	localparam logic [5:0] op_slli  = 6'b101010;
	localparam logic [5:0] op_movi  = 6'b100010;
	localparam logic [5:0] op_lwi   = 6'b000010; // Address is ra + (imm15 << 2)
	localparam logic [5:0] op_swi   = 6'b001010;
	localparam logic [5:0] op_lw    = 6'b011100; // Address is ra + (index register << sv)
	localparam logic [5:0] op_sw    = 6'b011101; // Index register is rt, which is also the data

	localparam logic [4:0] fn_add = 5'b00000;
	localparam logic [4:0] fn_sub = 5'b00001;
	localparam logic [4:0] fn_and = 5'b00010;
	localparam logic [4:0] fn_xor = 5'b00011;
	localparam logic [4:0] fn_or  = 5'b00100;
	localparam logic [4:0] fn_sll = 5'b01100;

	// ##########################################################
	// Selector codes
	// ##########################################################
	localparam logic [2:0] alusrc2_rbdata = 3'd0;
	localparam logic [2:0] alusrc2_imm    = 3'd1;
	localparam logic [2:0] alusrc2_lswi   = 3'd2; // Sign-extended imm15 scaled to words
	localparam logic [2:0] alusrc2_lsw    = 3'd3;

	localparam logic [1:0] imm_5bit_ze  = 2'd0;
	localparam logic [1:0] imm_15bit_se = 2'd1;
	localparam logic [1:0] imm_15bit_ze = 2'd2;
	localparam logic [1:0] imm_20bit_se = 2'd3;

	localparam logic [1:0] wrreg_aluresult = 2'd0;
	localparam logic [1:0] wrreg_immdata   = 2'd1;
	localparam logic [1:0] wrreg_mem       = 2'd2;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_sll = 3'd5
	} alu_op_t;

	// Register view of the instruction word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic       rsvd_10;
		logic [1:0] sub_op_sv;
		logic [2:0] rsvd_7_5;
		logic [4:0] funct;
	} instr_reg_t;

	// Immediate view, the 20-bit field overlaps the low bits of ra
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic        rsvd_20;
		logic [19:0] imm_20bit;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_t;

endpackage

`default_nettype wire
